// File: compile.f
+incdir+include
rtl/qla_pkg.sv
rtl/qla_bus_ctrl.sv
rtl/qla_chan_regs.sv
rtl/qla_sampler.sv
rtl/qla_watchdog.sv
rtl/qla_top.sv
test/qla_bus_chk.sv
test/qla_tb.sv

// File: Bender.yml
package:
  name: qla_regs

sources:
  - include_dirs:
      - include
    files:
      - rtl/qla_pkg.sv
      - rtl/qla_bus_ctrl.sv
      - rtl/qla_chan_regs.sv
      - rtl/qla_sampler.sv
      - rtl/qla_watchdog.sv
      - rtl/qla_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/qla_bus_chk.sv
      - test/qla_tb.sv

// File: test/qla_tb.sv
// qla register block testbench: wishbone bus tasks and directed tests on the top level
`timescale 1ns/100ps
`include "qla_macros.svh"

module qla_tb;
    import qla_pkg::*;

    localparam int ACK_LIMIT = 50;   // cycles before a bus access is given up
    localparam int WDOG_P    = 4;    // watchdog period under test, in tick units

    logic                     sysclk;
    logic                     rst_n;
    board_id_t                board_id;
    wb_req_t                  wb_req;
    wb_rsp_t                  wb_rsp;
    adc_t [`QLA_NUM_CHAN-1:0] adc_in;
    dac_t [`QLA_NUM_CHAN-1:0] dac_out;
    logic [`QLA_NUM_CHAN-1:0] amp_en;
    logic                     wdog_timeout;
    dac_t [`QLA_NUM_CHAN-1:0] exp_dac;   // setpoints as written by the host
    logic [`QLA_NUM_CHAN-1:0] exp_amp;   // expected effective enables

    qla_top dut (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .board_id     (board_id),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .adc_in       (adc_in),
        .dac_out      (dac_out),
        .amp_en       (amp_en),
        .wdog_timeout (wdog_timeout)
    );

    initial sysclk = 1'b0;
    always #5 sysclk = ~sysclk;   // 100 MHz

    // word addresses, channel field n is motor channel n-1
    function automatic reg_addr_t chan_addr(input int c, input logic [3:0] off);
        return {8'h00, 4'(c + 1), off};
    endfunction

    function automatic reg_addr_t glb_addr(input logic [3:0] off);
        return {8'h00, `QLA_GLOBAL_SEL, off};
    endfunction

    function automatic reg_addr_t sample_addr(input int k);
        return {8'h00, `QLA_SAMPLE_SEL, 4'(k)};
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0d ns %s: got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge sysclk);
        #1;   // back to the drive point
    endtask

    task automatic wait_ack(output reg_data_t dat);
        int n;
        n   = 0;
        dat = '0;
        do begin
            @(posedge sysclk);
            #1;
            n++;
        end while (!wb_rsp.ack && n < ACK_LIMIT);
        if (!wb_rsp.ack) begin
            abort_run("timeout: the DUT never acknowledged the bus access");
        end else begin
            dat = wb_rsp.dat;
        end
    endtask

    // classic cycle, request held through the ack cycle
    task automatic bus_access(input logic we, input reg_addr_t adr, input reg_data_t wdat,
                              output reg_data_t rdat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        wait_ack(rdat);
        @(posedge sysclk);
        #1;
        wb_req.cyc = 1'b0;   // stb drops the cycle after ack
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        @(posedge sysclk);   // slave sees stb low, back to idle
        #1;
    endtask

    task automatic wb_write(input reg_addr_t adr, input reg_data_t dat);
        reg_data_t unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input reg_addr_t adr, output reg_data_t dat);
        bus_access(1'b0, adr, '0, dat);
    endtask

    task automatic reset_test();
        reg_data_t rd;
        check("amp_en after reset", amp_en, 32'd0);
        check("wdog_timeout after reset", wdog_timeout, 32'd0);
        check("ack after reset", wb_rsp.ack, 32'd0);
        wb_read(glb_addr(`QLA_OFF_STATUS), rd);
        check("status board id", rd[3:0], board_id);
        check("status flags", rd[31:30], 32'd0);   // no timeout, not busy
    endtask

    task automatic chan_test();
        reg_data_t rd;
        dac_t      dac;
        adc_t      adc;
        logic      en;
        for (int c = 0; c < `QLA_NUM_CHAN; c++) begin
            dac = dac_t'($urandom);
            en  = 1'($urandom);
            adc = adc_t'($urandom);
            wb_write(chan_addr(c, `QLA_OFF_DAC), {16'h0000, dac});
            exp_dac[c] = dac;
            wb_read(chan_addr(c, `QLA_OFF_DAC), rd);
            check("dac readback", rd, {16'h0000, dac});
            check("dac_out", dac_out[c], dac);
            wb_write(chan_addr(c, `QLA_OFF_AMP), {31'd0, en});
            exp_amp[c] = en;
            wb_read(chan_addr(c, `QLA_OFF_AMP), rd);
            check("amp readback", rd, {31'd0, en});
            check("amp_en", amp_en, exp_amp);
            adc_in[c] = adc;
            idle(4);   // two flop sync plus margin
            wb_read(chan_addr(c, `QLA_OFF_ADC), rd);
            check("adc readback", rd, {16'h0000, adc});
        end
    endtask

    task automatic sample_test();
        adc_t [`QLA_NUM_CHAN-1:0] old_adc;
        reg_data_t                rd;
        reg_data_t                ts_before;
        reg_data_t                ts_word;
        reg_data_t                ts_now;
        for (int c = 0; c < `QLA_NUM_CHAN; c++) begin
            exp_dac[c] = dac_t'($urandom);
            wb_write(chan_addr(c, `QLA_OFF_DAC), {16'h0000, exp_dac[c]});
            adc_in[c] = adc_t'($urandom);
        end
        old_adc = adc_in;
        wb_read(glb_addr(`QLA_OFF_TSTAMP), ts_before);   // counter before the trigger
        wb_write(glb_addr(`QLA_OFF_SAMPLE), 32'h1);
        for (int c = 0; c < `QLA_NUM_CHAN; c++) adc_in[c] = ~old_adc[c];   // moves after trigger
        for (int k = 1; k <= `QLA_NUM_CHAN; k++) begin
            wb_read(sample_addr(k), rd);
            check("sample word", rd, {exp_dac[k-1], old_adc[k-1]});   // dac high, adc low
        end
        wb_read(sample_addr(0), ts_word);
        wb_read(glb_addr(`QLA_OFF_TSTAMP), ts_now);
        check("sample timestamp after earlier read", ts_before < ts_word, 32'd1);
        check("sample timestamp not after later read", ts_word <= ts_now, 32'd1);
    endtask

    task automatic backpressure_test();
        reg_data_t rd;
        // captures the inputs left by the sample test
        wb_write(glb_addr(`QLA_OFF_SAMPLE), 32'h1);
        wb_read(sample_addr(`QLA_NUM_CHAN), rd);   // last word, still being filled
        check("held buffer read", rd, {exp_dac[`QLA_NUM_CHAN-1], adc_in[`QLA_NUM_CHAN-1]});
        wb_read(sample_addr(1), rd);
        check("buffer word 1 after hold", rd, {exp_dac[0], adc_in[0]});
        wb_read(glb_addr(`QLA_OFF_STATUS), rd);
        check("status busy bit", rd[30], 32'd0);
    endtask

    task automatic watchdog_test();
        reg_data_t rd;
        wb_write(glb_addr(`QLA_OFF_WDOG), WDOG_P);
        wb_read(glb_addr(`QLA_OFF_WDOG), rd);
        check("watchdog period", rd, WDOG_P);
        for (int c = 0; c < `QLA_NUM_CHAN; c++) wb_write(chan_addr(c, `QLA_OFF_AMP), 32'h1);
        exp_amp = '1;
        check("amp_en armed", amp_en, exp_amp);
        for (int i = 0; i < 6; i++) begin
            idle(WDOG_P * `QLA_WDOG_TICK / 2);   // about half the period per gap
            wb_write(chan_addr(0, `QLA_OFF_DAC), {16'h0000, exp_dac[0]});
            check("no timeout while kicked", wdog_timeout, 32'd0);
            check("amp_en while kicked", amp_en, exp_amp);
        end
        idle(WDOG_P * `QLA_WDOG_TICK + 32);
        check("timeout after idle", wdog_timeout, 32'd1);
        check("amp_en forced off", amp_en, 32'd0);
        wb_write(chan_addr(1, `QLA_OFF_AMP), 32'h1);
        wb_read(chan_addr(1, `QLA_OFF_AMP), rd);
        check("enable ignored in timeout", rd, 32'd0);
        check("amp_en stays off", amp_en, 32'd0);
        exp_amp = '0;   // enables dropped for good
        wb_write(glb_addr(`QLA_OFF_WDOG), 32'd0);     // watchdog off
        wb_write(glb_addr(`QLA_OFF_STATUS), 32'd0);   // zero in bit 31 clears the flag
        check("timeout cleared", wdog_timeout, 32'd0);
        wb_read(glb_addr(`QLA_OFF_STATUS), rd);
        check("status after clear", rd, {28'd0, board_id});
        check("amp_en after clear", amp_en, exp_amp);
    endtask

    task automatic unmapped_test();
        reg_data_t rd;
        reg_addr_t bad;
        bad = chan_addr(0, `QLA_OFF_DAC) | 16'h0100;   // upper byte set
        wb_write(bad, ~{16'h0000, exp_dac[0]});
        wb_write(bad | 16'h0002, 32'h1);   // same slot as the channel 0 enable
        wb_read(chan_addr(0, `QLA_OFF_DAC), rd);
        check("dac untouched", rd, {16'h0000, exp_dac[0]});
        check("dac_out untouched", dac_out[0], exp_dac[0]);
        check("amp_en untouched", amp_en, exp_amp);
        wb_read(bad, rd);
        check("unmapped read", rd, 32'd0);
    endtask

    initial begin
        void'($urandom(32'h0f32_253e));
        rst_n    = 1'b0;
        board_id = 4'hA;
        wb_req   = '0;
        adc_in   = '0;
        exp_dac  = '0;
        exp_amp  = '0;
        repeat (4) @(posedge sysclk);
        #1;
        rst_n = 1'b1;
        reset_test();
        chan_test();
        sample_test();
        backpressure_test();
        watchdog_test();
        unmapped_test();
        if (dut.u_chk.fail_cnt != 0) begin
            abort_run("the bound bus checker saw failing assertions");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// File: test/qla_bus_chk.sv
// qla bus checker: concurrent assertions on wishbone ack and amplifier safety
`timescale 1ns/100ps
`include "qla_macros.svh"

module qla_bus_chk (
    input logic                     sysclk,
    input logic                     rst_n,
    input qla_pkg::wb_req_t         wb_req,
    input qla_pkg::wb_rsp_t         wb_rsp,
    input logic [`QLA_NUM_CHAN-1:0] amp_en,
    input logic                     wdog_timeout
);
    int fail_cnt = 0;   // failed assertions so far

    // ack is a single cycle pulse
    ack_one_cycle: assert property (@(posedge sysclk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
    else begin
        fail_cnt++;
        $error("ack held high for more than one cycle");
    end

    // no ack without a live request
    ack_needs_req: assert property (@(posedge sysclk) disable iff (!rst_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
    else begin
        fail_cnt++;
        $error("ack without cyc and stb");
    end

    amp_off_in_timeout: assert property (@(posedge sysclk) disable iff (!rst_n)
        wdog_timeout |-> (amp_en == '0))
    else begin
        fail_cnt++;
        $error("amplifier enabled during watchdog timeout");
    end

endmodule

bind qla_top qla_bus_chk u_chk (
    .sysclk       (sysclk),
    .rst_n        (rst_n),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .amp_en       (amp_en),
    .wdog_timeout (wdog_timeout)
);

// File: rtl/qla_top.sv
// qla register block top: bus controller with channel, sampler and watchdog datapaths
`timescale 1ns/100ps
`include "qla_macros.svh"

module qla_top (
    input  logic                                 sysclk,
    input  logic                                 rst_n,
    input  qla_pkg::board_id_t                   board_id,
    input  qla_pkg::wb_req_t                     wb_req,
    output qla_pkg::wb_rsp_t                     wb_rsp,
    input  qla_pkg::adc_t [`QLA_NUM_CHAN-1:0]    adc_in,
    output qla_pkg::dac_t [`QLA_NUM_CHAN-1:0]    dac_out,
    output logic [`QLA_NUM_CHAN-1:0]             amp_en,
    output logic                                 wdog_timeout
);
    import qla_pkg::*;

    chan_wr_t   chan_wr;           // channel write and read select
    reg_data_t  chan_rdata;
    logic       sample_start;
    logic [2:0] sample_idx;        // buffer word
    reg_data_t  sample_rdata;
    logic       sample_busy;
    tstamp_t    timestamp;
    logic       wdog_kick;
    logic       wdog_clear;
    logic       wdog_period_wen;
    reg_data_t  wdog_period;

    qla_bus_ctrl u_ctrl (
        .sysclk          (sysclk),
        .rst_n           (rst_n),
        .board_id        (board_id),
        .wb_req          (wb_req),
        .wb_rsp          (wb_rsp),
        .chan_wr         (chan_wr),
        .chan_rdata      (chan_rdata),
        .sample_start    (sample_start),
        .sample_idx      (sample_idx),
        .sample_rdata    (sample_rdata),
        .sample_busy     (sample_busy),
        .timestamp       (timestamp),
        .wdog_kick       (wdog_kick),
        .wdog_clear      (wdog_clear),
        .wdog_period_wen (wdog_period_wen),
        .wdog_period     (wdog_period),
        .wdog_timeout    (wdog_timeout)
    );

    qla_chan_regs u_chan (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .chan_wr      (chan_wr),
        .rd_chan      (chan_wr.chan),   // read select shares the decode
        .rd_off       (chan_wr.off),
        .rdata        (chan_rdata),
        .adc_in       (adc_in),
        .dac_out      (dac_out),
        .amp_en       (amp_en),
        .wdog_timeout (wdog_timeout)
    );

    qla_sampler u_sampler (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .sample_start (sample_start),
        .rd_idx       (sample_idx),
        .rdata        (sample_rdata),
        .busy         (sample_busy),
        .timestamp    (timestamp),
        .dac_in       (dac_out),        // setpoints as driven
        .adc_in       (adc_in)
    );

    qla_watchdog u_wdog (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .kick         (wdog_kick),
        .clear        (wdog_clear),
        .period_wen   (wdog_period_wen),
        .period_wdata (chan_wr.data),   // host write data
        .period       (wdog_period),
        .timeout      (wdog_timeout)
    );

endmodule

// File: rtl/qla_watchdog.sv
// qla watchdog: drops a sticky timeout flag when host writes stop for the set period
`timescale 1ns/100ps
`include "qla_macros.svh"

module qla_watchdog (
    input  logic               sysclk,
    input  logic               rst_n,
    input  logic               kick,
    input  logic               clear,
    input  logic               period_wen,
    input  qla_pkg::reg_data_t period_wdata,
    output qla_pkg::reg_data_t period,
    output logic               timeout
);
    localparam int TICK_W = $clog2(`QLA_WDOG_TICK);

    logic [15:0]       period_q;   // in tick units, 0 = off
    logic [TICK_W-1:0] presc;      // sysclk cycles within a unit
    logic [15:0]       unit_cnt;   // elapsed units since last kick
    logic              tick;
    logic              enabled;

    assign enabled = (period_q != 16'd0);
    assign tick    = (presc == TICK_W'(`QLA_WDOG_TICK - 1));

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            period_q <= '0;
            presc    <= '0;
            unit_cnt <= '0;
            timeout  <= 1'b0;
        end else begin
            if (period_wen) period_q <= period_wdata[15:0];

            // count frozen while off or already expired
            if (kick || clear || !enabled || timeout) begin
                presc    <= '0;
                unit_cnt <= '0;
            end else if (tick) begin
                presc    <= '0;
                unit_cnt <= unit_cnt + 16'd1;
            end else begin
                presc <= presc + 1'b1;
            end

            if (clear) begin
                timeout <= 1'b0;
            end else if (enabled && !kick && unit_cnt >= period_q) begin
                timeout <= 1'b1;                       // sticky
            end
        end
    end

    assign period = {16'd0, period_q};

endmodule

// File: rtl/qla_sampler.sv
// qla sampler: free-running timestamp and one-shot capture of all channels into a buffer
`timescale 1ns/100ps
`include "qla_macros.svh"

module qla_sampler (
    input  logic                                 sysclk,
    input  logic                                 rst_n,
    input  logic                                 sample_start,
    input  logic [2:0]                           rd_idx,
    output qla_pkg::reg_data_t                   rdata,
    output logic                                 busy,
    output qla_pkg::tstamp_t                     timestamp,
    input  qla_pkg::dac_t [`QLA_NUM_CHAN-1:0]    dac_in,
    input  qla_pkg::adc_t [`QLA_NUM_CHAN-1:0]    adc_in
);
    import qla_pkg::*;

    localparam int NWORDS = `QLA_SAMPLE_WORDS;

    tstamp_t                  ts_q;
    tstamp_t                  ts_snap;                // timestamp at start
    dac_t [`QLA_NUM_CHAN-1:0] dac_snap;
    adc_t [`QLA_NUM_CHAN-1:0] adc_snap;
    reg_data_t                sample_buf [NWORDS];
    logic [2:0]               wr_idx;                 // word being written
    reg_data_t                wr_word;
    chan_idx_t                wr_chan;
    logic                     take;                   // accepted start

    assign take    = sample_start && !busy;           // start while busy dropped
    assign wr_chan = chan_idx_t'(wr_idx - 3'd1);

    // word 0 timestamp, word k is dac/adc of channel k-1
    always_comb begin
        if (wr_idx == 3'd0) wr_word = ts_snap;
        else                wr_word = {dac_snap[wr_chan], adc_snap[wr_chan]};
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            ts_q   <= '0;
            busy   <= 1'b0;
            wr_idx <= '0;
        end else begin
            ts_q <= ts_q + 1'b1;                      // free running, wraps
            if (take) begin
                busy   <= 1'b1;
                wr_idx <= '0;
            end else if (busy) begin
                wr_idx <= wr_idx + 3'd1;
                if (wr_idx == 3'(NWORDS - 1)) busy <= 1'b0;   // last word this clock
            end
        end
    end

    // snapshot everything at once, then walk it into the buffer
    always_ff @(posedge sysclk) begin
        if (take) begin
            ts_snap  <= ts_q;
            dac_snap <= dac_in;
            adc_snap <= adc_in;
        end
        if (busy) sample_buf[wr_idx] <= wr_word;
    end

    assign timestamp = ts_q;
    assign rdata     = (rd_idx < 3'(NWORDS)) ? sample_buf[rd_idx] : '0;

endmodule

// File: rtl/qla_chan_regs.sv
// qla channel registers: DAC setpoints, amplifier enables and synchronized ADC readback
`timescale 1ns/100ps
`include "qla_macros.svh"

module qla_chan_regs (
    input  logic                                 sysclk,
    input  logic                                 rst_n,
    input  qla_pkg::chan_wr_t                    chan_wr,
    input  qla_pkg::chan_idx_t                   rd_chan,
    input  logic [3:0]                           rd_off,
    output qla_pkg::reg_data_t                   rdata,
    input  qla_pkg::adc_t [`QLA_NUM_CHAN-1:0]    adc_in,
    output qla_pkg::dac_t [`QLA_NUM_CHAN-1:0]    dac_out,
    output logic [`QLA_NUM_CHAN-1:0]             amp_en,
    input  logic                                 wdog_timeout
);
    import qla_pkg::*;

    dac_t [`QLA_NUM_CHAN-1:0] dac_q;      // current setpoints
    logic [`QLA_NUM_CHAN-1:0] amp_q;      // requested enables
    adc_t [`QLA_NUM_CHAN-1:0] adc_meta;   // first sync stage
    adc_t [`QLA_NUM_CHAN-1:0] adc_sync;   // second stage, safe to use

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            dac_q <= '0;
            amp_q <= '0;
        end else begin
            if (chan_wr.wen && chan_wr.off == `QLA_OFF_DAC) begin
                dac_q[chan_wr.chan] <= chan_wr.data[$bits(dac_t)-1:0];
            end
            // timeout drops every enable, host must re-enable after clear
            if (wdog_timeout) begin
                amp_q <= '0;
            end else if (chan_wr.wen && chan_wr.off == `QLA_OFF_AMP) begin
                amp_q[chan_wr.chan] <= chan_wr.data[0];
            end
        end
    end

    // two flop synchronizer on the ADC words
    always_ff @(posedge sysclk) begin
        adc_meta <= adc_in;
        adc_sync <= adc_meta;
    end

    assign dac_out = dac_q;
    // mask covers the clock before amp_q clears
    assign amp_en  = amp_q & ~{`QLA_NUM_CHAN{wdog_timeout}};

    always_comb begin
        case (rd_off)
            `QLA_OFF_DAC: rdata = {16'd0, dac_q[rd_chan]};
            `QLA_OFF_ADC: rdata = {16'd0, adc_sync[rd_chan]};
            `QLA_OFF_AMP: rdata = {31'd0, amp_en[rd_chan]};   // effective state
            default:      rdata = '0;
        endcase
    end

endmodule

// File: rtl/qla_bus_ctrl.sv
// qla bus controller: wishbone slave FSM, address decode, read mux and command pulses
`timescale 1ns/100ps
`include "qla_macros.svh"

module qla_bus_ctrl (
    input  logic               sysclk,
    input  logic               rst_n,
    input  qla_pkg::board_id_t board_id,
    input  qla_pkg::wb_req_t   wb_req,
    output qla_pkg::wb_rsp_t   wb_rsp,
    output qla_pkg::chan_wr_t  chan_wr,
    input  qla_pkg::reg_data_t chan_rdata,
    output logic               sample_start,
    output logic [2:0]         sample_idx,
    input  qla_pkg::reg_data_t sample_rdata,
    input  logic               sample_busy,
    input  qla_pkg::tstamp_t   timestamp,
    output logic               wdog_kick,
    output logic               wdog_clear,
    output logic               wdog_period_wen,
    input  qla_pkg::reg_data_t wdog_period,
    input  logic               wdog_timeout
);
    import qla_pkg::*;

    bus_state_t state;
    logic       ack_q;
    reg_data_t  dat_q;
    reg_data_t  rd_mux;
    logic [3:0] fld;           // channel field
    logic [3:0] off;           // register offset
    logic       upper_ok;      // bits 15:8 clear
    logic       sel_global;
    logic       sel_chan;
    logic       sel_sample;
    logic       sample_word;   // valid buffer word
    logic       accept;        // new cycle taken this clock
    logic       wr_acc;
    logic       glb_wr;
    logic       load_dat;

    assign fld      = wb_req.adr[7:4];
    assign off      = wb_req.adr[3:0];
    assign upper_ok = (wb_req.adr[15:8] == 8'h00);

    assign sel_global  = upper_ok && (fld == `QLA_GLOBAL_SEL);
    assign sel_chan    = upper_ok && (fld >= 4'd1) && (fld <= 4'(`QLA_NUM_CHAN));
    assign sel_sample  = upper_ok && (fld == `QLA_SAMPLE_SEL);
    assign sample_word = sel_sample && (off < 4'(`QLA_SAMPLE_WORDS));

    assign accept = (state == idle) && wb_req.cyc && wb_req.stb;
    assign wr_acc = accept && wb_req.we;
    assign glb_wr = wr_acc && sel_global;

    // channel port, chan/off stay live for the read mux
    assign chan_wr.wen  = wr_acc && sel_chan;
    assign chan_wr.chan = chan_idx_t'(fld - 4'd1);   // field n -> channel n-1
    assign chan_wr.off  = off;
    assign chan_wr.data = wb_req.dat;

    // command pulses, one clock since the FSM leaves idle
    assign sample_start    = glb_wr && (off == `QLA_OFF_SAMPLE);
    assign wdog_period_wen = glb_wr && (off == `QLA_OFF_WDOG);
    assign wdog_clear      = glb_wr && (off == `QLA_OFF_STATUS) && !wb_req.dat[31];
    assign wdog_kick       = (glb_wr && (off <= `QLA_OFF_SAMPLE)) ||
                             (chan_wr.wen && (off == `QLA_OFF_DAC || off == `QLA_OFF_AMP));

    assign sample_idx = off[2:0];

    always_comb begin
        rd_mux = '0;   // unmapped reads as zero
        if (sel_global) begin
            case (off)
                `QLA_OFF_STATUS: rd_mux = {wdog_timeout, sample_busy, 26'd0, board_id};
                `QLA_OFF_WDOG:   rd_mux = wdog_period;
                `QLA_OFF_TSTAMP: rd_mux = timestamp;
                `QLA_OFF_SAMPLE: rd_mux = {31'd0, sample_busy};
                default:         rd_mux = '0;
            endcase
        end else if (sel_chan) begin
            rd_mux = chan_rdata;                           // 0 for unknown offsets
        end else if (sample_word) begin
            rd_mux = sample_rdata;
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state <= idle;
            ack_q <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (accept) begin
                        if (sample_word && !wb_req.we && sample_busy) begin
                            state <= wait_sample;   // hold off until capture ends
                        end else begin
                            ack_q <= 1'b1;
                            state <= respond;
                        end
                    end
                end
                wait_sample: begin
                    if (!wb_req.cyc) begin
                        state <= idle;              // master gave up
                    end else if (!sample_busy) begin
                        ack_q <= 1'b1;
                        state <= respond;
                    end
                end
                respond: begin
                    ack_q <= 1'b0;
                    // back to idle once stb drops, no double accept
                    if (!(wb_req.cyc && wb_req.stb)) state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // registered read data
    assign load_dat = accept || (state == wait_sample && !sample_busy);

    always_ff @(posedge sysclk) begin
        if (load_dat) dat_q <= rd_mux;
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = dat_q;

endmodule

// File: rtl/qla_pkg.sv
// qla shared types: register words, converter words, bus structs and controller states
package qla_pkg;

    typedef logic [15:0] reg_addr_t;   // word address, 15:8 zero, 7:4 chan, 3:0 offset
    typedef logic [31:0] reg_data_t;
    typedef logic [1:0]  chan_idx_t;   // motor channel 0..3
    typedef logic [15:0] dac_t;
    typedef logic [15:0] adc_t;
    typedef logic [3:0]  board_id_t;   // rotary switch
    typedef logic [31:0] tstamp_t;

    // host to slave, held until ack
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        reg_addr_t adr;
        reg_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic      ack;   // one cycle
        reg_data_t dat;
    } wb_rsp_t;

    // channel register write port, chan/off also steer the read mux
    typedef struct packed {
        logic       wen;
        chan_idx_t  chan;
        logic [3:0] off;
        reg_data_t  data;
    } chan_wr_t;

    typedef enum logic [1:0] {
        idle,
        respond,
        wait_sample   // buffer read held off while capture runs
    } bus_state_t;

endpackage

// File: include/qla_macros.svh
// qla register block constants: channel count, address map fields and watchdog tick
`ifndef QLA_MACROS_SVH
`define QLA_MACROS_SVH

// motor channels on the board
`define QLA_NUM_CHAN       4

// channel field values, bits 7:4 of the word address
`define QLA_GLOBAL_SEL     4'h0
`define QLA_SAMPLE_SEL     4'hF

// per-channel register offsets
`define QLA_OFF_DAC        4'd0
`define QLA_OFF_ADC        4'd1   // read only
`define QLA_OFF_AMP        4'd2

// global register offsets
`define QLA_OFF_STATUS     4'd0
`define QLA_OFF_WDOG       4'd1
`define QLA_OFF_TSTAMP     4'd2
`define QLA_OFF_SAMPLE     4'd3

// sample buffer depth, timestamp word plus one word per channel
`define QLA_SAMPLE_WORDS   (`QLA_NUM_CHAN + 1)

`define QLA_WDOG_TICK      16     // sysclk cycles per period unit

`endif
